// ==== dword_buffer.sv ====
// Four-lane byte buffer, lane 0 is the least significant byte; a dword load beats clear
`timescale 1ns/1ns
`default_nettype none

module dword_buffer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  logic                               load_byte_i,
  input  logic [i2c_standby_pkg::BYTE_W-1:0]  byte_i,
  input  logic [1:0]                         lane_i,
  input  logic                               load_dword_i,
  input  logic [i2c_standby_pkg::DWORD_W-1:0] dword_i,
  output logic [i2c_standby_pkg::DWORD_W-1:0] dword_o,
  output logic [i2c_standby_pkg::BYTE_W-1:0]  byte_o
);

  import i2c_standby_pkg::*;

  logic [3:0][BYTE_W-1:0] lanes_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lanes_q <= '0;
    end else if (load_dword_i) begin
      lanes_q <= dword_i;
    end else begin
      if (clear_i) begin
        lanes_q <= '0;
      end
      // A byte load in the same cycle as clear still lands in its lane
      if (load_byte_i) begin
        lanes_q[lane_i] <= byte_i;
      end
    end
  end

  assign dword_o = lanes_q;
  assign byte_o  = lanes_q[lane_i];

endmodule : dword_buffer

`default_nettype wire

// ==== i2c_standby_pkg.sv ====
// Shared types and sizes for the I2C standby bridge; queue depths must be powers of two
`default_nettype none

package i2c_standby_pkg;

  // Sizing
  localparam int DWORD_W    = 32;
  localparam int BYTE_W     = 8;
  localparam int LEN_W      = 16;
  localparam int CMD_DEPTH  = 4;
  localparam int DATA_DEPTH = 8;
  localparam int RESP_DEPTH = 4;

  // Event kinds from the I2C target acquisition path
  typedef enum logic [2:0] {
    AcqData    = 3'd0,
    AcqStart   = 3'd1,
    AcqStop    = 3'd2,
    AcqRestart = 3'd3,
    AcqNack    = 3'd4
  } acq_id_e;

  // One acquisition word; address bit 0 is the direction on start and restart
  typedef struct packed {
    acq_id_e           id;
    logic [BYTE_W-1:0] data;
  } acq_event_t;

  // Read command from the TTI command queue
  typedef struct packed {
    logic [LEN_W-1:0] data_length;
    logic [7:0]       reserved;
  } tti_cmd_desc_t;

  // Response written at the end of a write transfer
  typedef struct packed {
    logic [LEN_W-1:0] data_length;
    logic             err;
  } tti_resp_desc_t;

  // Bridge flow states
  typedef enum logic [3:0] {
    AwaitStart   = 4'd0,
    ReceiveByte  = 4'd1,
    PushDWord    = 4'd2,
    PushResponse = 4'd3,
    PopCommand   = 4'd4,
    PopDWord     = 4'd5,
    SendByte     = 4'd6,
    SwitchByte   = 4'd7,
    AwaitStop    = 4'd8,
    ReportError  = 4'd9
  } flow_state_e;

endpackage : i2c_standby_pkg

`default_nettype wire

// ==== i2c_standby_top.sv ====
// Standby bridge top with internal TTI queues; no register interface and no queue thresholds
`timescale 1ns/1ns
`default_nettype none

module i2c_standby_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  input  logic                               acq_valid_i,
  input  i2c_standby_pkg::acq_event_t         acq_i,

  input  logic                               cmd_push_valid_i,
  input  i2c_standby_pkg::tti_cmd_desc_t      cmd_push_i,
  output logic                               cmd_push_ready_o,

  input  logic                               tx_push_valid_i,
  input  logic [i2c_standby_pkg::DWORD_W-1:0] tx_push_i,
  output logic                               tx_push_ready_o,

  input  logic                               rx_pop_ready_i,
  output logic                               rx_pop_valid_o,
  output logic [i2c_standby_pkg::DWORD_W-1:0] rx_pop_o,

  input  logic                               resp_pop_ready_i,
  output logic                               resp_pop_valid_o,
  output i2c_standby_pkg::tti_resp_desc_t     resp_pop_o,

  input  logic                               tx_byte_ready_i,
  output logic                               tx_byte_valid_o,
  output logic [i2c_standby_pkg::BYTE_W-1:0]  tx_byte_o,

  output logic                               err_o
);

  import i2c_standby_pkg::*;

  // Queue read and write sides facing the FSM
  tti_cmd_desc_t    cmd_rdata;
  logic             cmd_rvalid;
  logic             cmd_rready;
  logic [DWORD_W-1:0] tx_rdata;
  logic             tx_rvalid;
  logic             tx_rready;
  logic [DWORD_W-1:0] rx_wdata;
  logic             rx_wvalid;
  logic             rx_wready;
  tti_resp_desc_t   resp_wdata;
  logic             resp_wvalid;
  logic             resp_wready;

  // Counter and buffer controls
  logic [LEN_W-1:0] count;
  logic [LEN_W-1:0] length;
  logic [1:0]       lane;
  logic             last_byte;
  logic             cnt_clear;
  logic             cnt_inc;
  logic             buf_clear;
  logic             buf_load_byte;
  logic             buf_load_dword;

  standby_flow_fsm u_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .acq_valid_i      (acq_valid_i),
    .acq_i            (acq_i),
    .cmd_valid_i      (cmd_rvalid),
    .cmd_i            (cmd_rdata),
    .cmd_ready_o      (cmd_rready),
    .tx_valid_i       (tx_rvalid),
    .tx_ready_o       (tx_rready),
    .rx_ready_i       (rx_wready),
    .rx_valid_o       (rx_wvalid),
    .resp_ready_i     (resp_wready),
    .resp_valid_o     (resp_wvalid),
    .resp_o           (resp_wdata),
    .byte_ready_i     (tx_byte_ready_i),
    .byte_valid_o     (tx_byte_valid_o),
    .count_i          (count),
    .lane_i           (lane),
    .last_byte_i      (last_byte),
    .length_o         (length),
    .cnt_clear_o      (cnt_clear),
    .cnt_inc_o        (cnt_inc),
    .buf_clear_o      (buf_clear),
    .buf_load_byte_o  (buf_load_byte),
    .buf_load_dword_o (buf_load_dword),
    .err_o            (err_o)
  );

  xfer_byte_counter u_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (cnt_clear),
    .inc_i       (cnt_inc),
    .length_i    (length),
    .count_o     (count),
    .lane_o      (lane),
    .last_byte_o (last_byte)
  );

  dword_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (buf_clear),
    .load_byte_i  (buf_load_byte),
    .byte_i       (acq_i.data),
    .lane_i       (lane),
    .load_dword_i (buf_load_dword),
    .dword_i      (tx_rdata),
    .dword_o      (rx_wdata),
    .byte_o       (tx_byte_o)
  );

  sync_fifo #(.WIDTH($bits(tti_cmd_desc_t)), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (cmd_push_valid_i),
    .wready_o (cmd_push_ready_o),
    .wdata_i  (cmd_push_i),
    .rvalid_o (cmd_rvalid),
    .rready_i (cmd_rready),
    .rdata_o  (cmd_rdata)
  );

  sync_fifo #(.WIDTH(DWORD_W), .DEPTH(DATA_DEPTH)) u_tx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (tx_push_valid_i),
    .wready_o (tx_push_ready_o),
    .wdata_i  (tx_push_i),
    .rvalid_o (tx_rvalid),
    .rready_i (tx_rready),
    .rdata_o  (tx_rdata)
  );

  sync_fifo #(.WIDTH(DWORD_W), .DEPTH(DATA_DEPTH)) u_rx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rx_wvalid),
    .wready_o (rx_wready),
    .wdata_i  (rx_wdata),
    .rvalid_o (rx_pop_valid_o),
    .rready_i (rx_pop_ready_i),
    .rdata_o  (rx_pop_o)
  );

  sync_fifo #(.WIDTH($bits(tti_resp_desc_t)), .DEPTH(RESP_DEPTH)) u_resp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (resp_wvalid),
    .wready_o (resp_wready),
    .wdata_i  (resp_wdata),
    .rvalid_o (resp_pop_valid_o),
    .rready_i (resp_pop_ready_i),
    .rdata_o  (resp_pop_o)
  );

endmodule : i2c_standby_top

`default_nettype wire

// ==== standby_flow_fsm.sv ====
// Bridge flow control; events that arrive during a stalled queue push or a read are errors
`timescale 1ns/1ns
`default_nettype none

module standby_flow_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             acq_valid_i,
  input  i2c_standby_pkg::acq_event_t       acq_i,

  input  logic                             cmd_valid_i,
  input  i2c_standby_pkg::tti_cmd_desc_t    cmd_i,
  output logic                             cmd_ready_o,

  input  logic                             tx_valid_i,
  output logic                             tx_ready_o,

  input  logic                             rx_ready_i,
  output logic                             rx_valid_o,

  input  logic                             resp_ready_i,
  output logic                             resp_valid_o,
  output i2c_standby_pkg::tti_resp_desc_t   resp_o,

  input  logic                             byte_ready_i,
  output logic                             byte_valid_o,

  input  logic [i2c_standby_pkg::LEN_W-1:0] count_i,
  input  logic [1:0]                       lane_i,
  input  logic                             last_byte_i,
  output logic [i2c_standby_pkg::LEN_W-1:0] length_o,
  output logic                             cnt_clear_o,
  output logic                             cnt_inc_o,

  output logic                             buf_clear_o,
  output logic                             buf_load_byte_o,
  output logic                             buf_load_dword_o,

  output logic                             err_o
);

  import i2c_standby_pkg::*;

  flow_state_e      state_q;
  flow_state_e      state_d;
  tti_resp_desc_t   resp_q;
  logic [LEN_W-1:0] length_q;

  // Write end seen, response still owed
  logic ending_q;
  // The write was ended by a restart and its transfer is still to begin
  logic restart_q;
  logic restart_read_q;

  logic is_start;
  logic is_restart;
  logic is_stop;
  logic is_data;
  logic xfer_end;
  logic addr_read;
  logic begin_xfer;
  logic begin_read;
  logic latch_end;
  logic pop_cmd;

  assign is_start   = acq_valid_i && (acq_i.id == AcqStart);
  assign is_restart = acq_valid_i && (acq_i.id == AcqRestart);
  assign is_stop    = acq_valid_i && (acq_i.id == AcqStop);
  assign is_data    = acq_valid_i && (acq_i.id == AcqData);
  assign xfer_end   = is_stop | is_restart;
  assign addr_read  = acq_i.data[0];
  assign pop_cmd    = (state_q == PopCommand) && cmd_valid_i;

  assign resp_o   = resp_q;
  assign length_o = length_q;

  always_comb begin
    state_d          = state_q;
    cmd_ready_o      = 1'b0;
    tx_ready_o       = 1'b0;
    rx_valid_o       = 1'b0;
    resp_valid_o     = 1'b0;
    byte_valid_o     = 1'b0;
    cnt_clear_o      = 1'b0;
    cnt_inc_o        = 1'b0;
    buf_clear_o      = 1'b0;
    buf_load_byte_o  = 1'b0;
    buf_load_dword_o = 1'b0;
    err_o            = 1'b0;
    begin_xfer       = 1'b0;
    begin_read       = addr_read;
    latch_end        = 1'b0;

    unique case (state_q)
      AwaitStart: begin
        // A stray stop while idle is harmless
        if (is_start) begin
          begin_xfer = 1'b1;
        end else if (acq_valid_i && !is_stop) begin
          state_d = ReportError;
        end
      end
      ReceiveByte: begin
        if (is_data) begin
          buf_load_byte_o = 1'b1;
          cnt_inc_o       = 1'b1;
          if (lane_i == 2'd3) begin
            state_d = PushDWord;
          end
        end else if (xfer_end) begin
          latch_end = 1'b1;
          // Flush a partial dword before the response
          state_d = (lane_i != 2'd0) ? PushDWord : PushResponse;
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      PushDWord: begin
        rx_valid_o = 1'b1;
        latch_end  = xfer_end && !ending_q;
        if (acq_valid_i && !latch_end && !(is_data && rx_ready_i && !ending_q)) begin
          state_d = ReportError;
        end else if (rx_ready_i) begin
          buf_clear_o = 1'b1;
          if (ending_q || latch_end) begin
            state_d = PushResponse;
          end else begin
            // A byte taken with the push starts the next dword in lane 0
            buf_load_byte_o = is_data;
            cnt_inc_o       = is_data;
            state_d         = ReceiveByte;
          end
        end
      end
      PushResponse: begin
        resp_valid_o = 1'b1;
        if (resp_ready_i) begin
          if (is_start || is_restart) begin
            begin_xfer = 1'b1;
          end else if (restart_q) begin
            begin_xfer = 1'b1;
            begin_read = restart_read_q;
          end else if (acq_valid_i && !is_stop) begin
            state_d = ReportError;
          end else begin
            state_d = AwaitStart;
          end
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      PopCommand: begin
        cmd_ready_o = 1'b1;
        if (acq_valid_i) begin
          state_d = ReportError;
        end else if (cmd_valid_i) begin
          state_d = (cmd_i.data_length == '0) ? ReportError : PopDWord;
        end
      end
      PopDWord: begin
        tx_ready_o = 1'b1;
        if (acq_valid_i) begin
          state_d = ReportError;
        end else if (tx_valid_i) begin
          buf_load_dword_o = 1'b1;
          state_d          = SendByte;
        end
      end
      SendByte: begin
        byte_valid_o = 1'b1;
        if (acq_valid_i) begin
          state_d = ReportError;
        end else if (byte_ready_i) begin
          cnt_inc_o = 1'b1;
          state_d   = last_byte_i ? AwaitStop : SwitchByte;
        end
      end
      SwitchByte: begin
        // Counter has moved on, lane 0 means the dword is used up
        if (acq_valid_i) begin
          state_d = ReportError;
        end else begin
          state_d = (lane_i == 2'd0) ? PopDWord : SendByte;
        end
      end
      AwaitStop: begin
        if (is_stop) begin
          state_d = AwaitStart;
        end else if (is_restart) begin
          begin_xfer = 1'b1;
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      ReportError: begin
        err_o = 1'b1;
      end
      default: begin
        state_d = ReportError;
      end
    endcase

    // Every new transfer starts from a zero count and an empty buffer
    if (begin_xfer) begin
      cnt_clear_o = 1'b1;
      buf_clear_o = 1'b1;
      state_d     = begin_read ? PopCommand : ReceiveByte;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= AwaitStart;
      ending_q       <= 1'b0;
      restart_q      <= 1'b0;
      restart_read_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (begin_xfer) begin
        ending_q  <= 1'b0;
        restart_q <= 1'b0;
      end else if (latch_end) begin
        ending_q       <= 1'b1;
        restart_q      <= is_restart;
        restart_read_q <= addr_read;
      end
    end
  end

  // Count is final when the ending event arrives
  always_ff @(posedge clk_i) begin
    if (latch_end) begin
      resp_q.data_length <= count_i;
      resp_q.err         <= 1'b0;
    end
    if (pop_cmd) begin
      length_q <= cmd_i.data_length;
    end
  end

endmodule : standby_flow_fsm

`default_nettype wire

// ==== standby_properties.sv ====
// Bound to standby_flow_fsm; an event during a read may abort a byte offer, reset is async
`timescale 1ns/1ns
`default_nettype none

module standby_properties (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         acq_valid_i,
  input logic                         byte_valid_i,
  input logic                         byte_ready_i,
  input logic [1:0]                   lane_i,
  input logic                         rx_valid_i,
  input logic                         resp_valid_i,
  input logic                         cmd_ready_i,
  input logic                         tx_ready_i,
  input logic                         err_i,
  input i2c_standby_pkg::flow_state_e state_i
);

  import i2c_standby_pkg::*;

  // Failed assertions, read by the testbench at the end
  int fail_count = 0;

  // An offered byte stays on its lane until taken
  byte_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_valid_i && !byte_ready_i && !acq_valid_i |=> byte_valid_i && $stable(lane_i))
  else begin
    fail_count++;
    $error("byte output changed before the handshake");
  end

  // Error state is sticky
  err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |=> err_i)
  else begin
    fail_count++;
    $error("err_o fell without a reset");
  end

  // Quiet outputs right after reset
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (state_i == AwaitStart) && !(byte_valid_i || rx_valid_i
      || resp_valid_i || cmd_ready_i || tx_ready_i || err_i))
  else begin
    fail_count++;
    $error("handshake or error output high in the first cycle after reset");
  end

endmodule : standby_properties

`default_nettype wire

// ==== sync_fifo.sv ====
// Synchronous valid/ready queue; DEPTH must be a power of two of at least 2, no reset on storage
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [WIDTH-1:0] wdata_i,

  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [WIDTH-1:0] rdata_o
);

  logic [WIDTH-1:0]         mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0] wptr_q;
  logic [$clog2(DEPTH)-1:0] rptr_q;
  logic [$clog2(DEPTH):0]   count_q;
  logic                     push;
  logic                     pop;

  // Full and empty come straight from the occupancy
  assign wready_o = (count_q != DEPTH);
  assign rvalid_o = (count_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;
  assign rdata_o  = mem_q[rptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule : sync_fifo

`default_nettype wire

// ==== tb.f ====
i2c_standby_pkg.sv
sync_fifo.sv
xfer_byte_counter.sv
dword_buffer.sv
standby_flow_fsm.sv
i2c_standby_top.sv
standby_properties.sv
tb_i2c_standby.sv

// ==== tb_i2c_standby.sv ====
// Testbench for the standby bridge; one acquisition event per cycle, fixed random seed
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_standby;

  import i2c_standby_pkg::*;

  typedef logic [BYTE_W-1:0]  byte_q_t[$];
  typedef logic [DWORD_W-1:0] dword_q_t[$];

  localparam int          CLK_PERIOD   = 10;
  localparam int          RST_CYCLES   = 8;
  localparam logic [31:0] SEED         = 32'hdef0_6c49;
  localparam logic [6:0]  TARGET_ADDR  = 7'h2a;
  localparam int          DRAIN_CYCLES = 200;
  localparam int          EVENT_BUDGET = 40;
  localparam int          NUM_TESTS    = 7;
  // Events and queue pushes of all tests together
  localparam int TOTAL_EVENTS = (9 + 2) + (6 + 4) + (10 + 5) + 4 + 5
                                + (4 * DATA_DEPTH + 6) + (7 + 2);
  localparam int TIMEOUT_NS   = CLK_PERIOD * (TOTAL_EVENTS * EVENT_BUDGET
                                + NUM_TESTS * (DRAIN_CYCLES + 2 * RST_CYCLES));

  logic               clk_i;
  logic               rst_ni;
  logic               acq_valid_i;
  acq_event_t         acq_i;
  logic               cmd_push_valid_i;
  tti_cmd_desc_t      cmd_push_i;
  logic               cmd_push_ready_o;
  logic               tx_push_valid_i;
  logic [DWORD_W-1:0] tx_push_i;
  logic               tx_push_ready_o;
  logic               rx_pop_ready_i;
  logic               rx_pop_valid_o;
  logic [DWORD_W-1:0] rx_pop_o;
  logic               resp_pop_ready_i;
  logic               resp_pop_valid_o;
  tti_resp_desc_t     resp_pop_o;
  logic               tx_byte_ready_i;
  logic               tx_byte_valid_o;
  logic [BYTE_W-1:0]  tx_byte_o;
  logic               err_o;

  // Testbench controls and expected results
  logic             pop_en;
  logic             stall_en;
  logic             ready_en;
  string            test_name;
  int               value_errs;
  int               flow_errs;
  int               bytes_seen;
  dword_q_t         exp_rx;
  logic [LEN_W-1:0] exp_resp[$];
  byte_q_t          exp_bytes;

  i2c_standby_top UUT (.*);

  bind standby_flow_fsm standby_properties u_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acq_valid_i  (acq_valid_i),
    .byte_valid_i (byte_valid_o),
    .byte_ready_i (byte_ready_i),
    .lane_i       (lane_i),
    .rx_valid_i   (rx_valid_o),
    .resp_valid_i (resp_valid_o),
    .cmd_ready_i  (cmd_ready_o),
    .tx_ready_i   (tx_ready_o),
    .err_i        (err_o),
    .state_i      (state_q)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Little-endian packing, lanes past the end of the data are zero
  function automatic logic [DWORD_W-1:0] expected_dword(input byte_q_t bytes, input int idx);
    logic [DWORD_W-1:0] dword;
    int k;
    dword = '0;
    for (k = 0; k < 4; k++) begin
      if (idx * 4 + k < bytes.size()) begin
        dword[8*k +: 8] = bytes[idx*4 + k];
      end
    end
    return dword;
  endfunction

  // Byte n of a read, least significant byte of each dword first
  function automatic logic [BYTE_W-1:0] expected_byte(input dword_q_t dwords, input int n);
    logic [DWORD_W-1:0] dword;
    dword = dwords[n / 4];
    return dword[8 * (n % 4) +: 8];
  endfunction

  // Ready inputs; stalls hold ready low about a quarter of the time
  always @(posedge clk_i) begin
    rx_pop_ready_i   <= pop_en;
    resp_pop_ready_i <= pop_en;
    tx_byte_ready_i  <= stall_en ? ($urandom_range(3, 0) != 0) : ready_en;
  end

  always @(posedge clk_i) begin : compare_outputs
    logic [DWORD_W-1:0] exp_dword;
    logic [LEN_W-1:0]   exp_len;
    logic [BYTE_W-1:0]  exp_byte;
    if (rst_ni && rx_pop_valid_o && rx_pop_ready_i) begin
      if (exp_rx.size() == 0) begin
        flow_errs++;
        $display("%s: unexpected RX dword %h", test_name, rx_pop_o);
      end else begin
        exp_dword = exp_rx.pop_front();
        if (rx_pop_o !== exp_dword) begin
          value_errs++;
          $display("error %s: RX dword expected %h, actual %h", test_name, exp_dword, rx_pop_o);
        end
      end
    end
    if (rst_ni && resp_pop_valid_o && resp_pop_ready_i) begin
      if (exp_resp.size() == 0) begin
        flow_errs++;
        $display("%s: unexpected response, length %0d", test_name, resp_pop_o.data_length);
      end else begin
        exp_len = exp_resp.pop_front();
        if (resp_pop_o.data_length !== exp_len || resp_pop_o.err !== 1'b0) begin
          value_errs++;
          $display("error %s: response expected len %0d err 0, actual len %0d err %b",
                   test_name, exp_len, resp_pop_o.data_length, resp_pop_o.err);
        end
      end
    end
    if (rst_ni && tx_byte_valid_o && tx_byte_ready_i) begin
      bytes_seen++;
      if (exp_bytes.size() == 0) begin
        flow_errs++;
        $display("%s: unexpected TX byte %h", test_name, tx_byte_o);
      end else begin
        exp_byte = exp_bytes.pop_front();
        if (tx_byte_o !== exp_byte) begin
          value_errs++;
          $display("error %s: TX byte expected %h, actual %h", test_name, exp_byte, tx_byte_o);
        end
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni           <= 1'b0;
    acq_valid_i      <= 1'b0;
    cmd_push_valid_i <= 1'b0;
    tx_push_valid_i  <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    exp_rx.delete();
    exp_resp.delete();
    exp_bytes.delete();
    rst_ni <= 1'b1;
  endtask

  task automatic send_event(input acq_id_e id, input logic [BYTE_W-1:0] data);
    @(posedge clk_i);
    acq_valid_i <= 1'b1;
    acq_i       <= '{id: id, data: data};
  endtask

  task automatic end_events();
    @(posedge clk_i);
    acq_valid_i <= 1'b0;
  endtask

  task automatic push_cmd(input logic [LEN_W-1:0] len);
    @(posedge clk_i);
    cmd_push_valid_i <= 1'b1;
    cmd_push_i       <= '{data_length: len, reserved: 8'h00};
    @(posedge clk_i);
    while (!cmd_push_ready_o) @(posedge clk_i);
    cmd_push_valid_i <= 1'b0;
  endtask

  task automatic push_tx(input logic [DWORD_W-1:0] data);
    @(posedge clk_i);
    tx_push_valid_i <= 1'b1;
    tx_push_i       <= data;
    @(posedge clk_i);
    while (!tx_push_ready_o) @(posedge clk_i);
    tx_push_valid_i <= 1'b0;
  endtask

  task automatic wait_error(input int limit);
    int n;
    n = 0;
    while (!err_o && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (!err_o) begin
      flow_errs++;
      $display("%s: err_o did not rise within %0d cycles", test_name, limit);
    end
  endtask

  task automatic drain_outputs();
    int n;
    n = 0;
    while ((exp_rx.size() + exp_resp.size() + exp_bytes.size()) != 0 && n < DRAIN_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    if ((exp_rx.size() + exp_resp.size() + exp_bytes.size()) != 0) begin
      flow_errs++;
      $display("%s: outputs missing, %0d RX dwords, %0d responses, %0d bytes", test_name,
               exp_rx.size(), exp_resp.size(), exp_bytes.size());
    end
    repeat (5) @(negedge clk_i);
    if (err_o) begin
      flow_errs++;
      $display("%s: err_o raised during a legal transfer", test_name);
    end
  endtask

  task automatic run_write(input string name, input int nbytes);
    byte_q_t bytes;
    int i;
    test_name <= name;
    for (i = 0; i < nbytes; i++) begin
      bytes.push_back(BYTE_W'($urandom));
    end
    for (i = 0; i < (nbytes + 3) / 4; i++) begin
      exp_rx.push_back(expected_dword(bytes, i));
    end
    exp_resp.push_back(LEN_W'(nbytes));
    send_event(AcqStart, {TARGET_ADDR, 1'b0});
    for (i = 0; i < nbytes; i++) begin
      send_event(AcqData, bytes[i]);
    end
    send_event(AcqStop, 8'h00);
    end_events();
    drain_outputs();
  endtask

  task automatic run_read(input string name, input int len, input logic stall);
    dword_q_t dwords;
    int i;
    int target;
    test_name <= name;
    for (i = 0; i < (len + 3) / 4; i++) begin
      dwords.push_back($urandom);
    end
    for (i = 0; i < len; i++) begin
      exp_bytes.push_back(expected_byte(dwords, i));
    end
    push_cmd(LEN_W'(len));
    for (i = 0; i < dwords.size(); i++) begin
      push_tx(dwords[i]);
    end
    target   = bytes_seen + len;
    stall_en <= stall;
    send_event(AcqStart, {TARGET_ADDR, 1'b1});
    end_events();
    i = 0;
    while (bytes_seen < target && i < len * EVENT_BUDGET) begin
      @(negedge clk_i);
      i++;
    end
    if (bytes_seen < target) begin
      flow_errs++;
      $display("%s: only %0d of %0d bytes delivered", test_name, len - (target - bytes_seen), len);
    end
    send_event(AcqStop, 8'h00);
    end_events();
    stall_en <= 1'b0;
    drain_outputs();
  endtask

  task automatic check_zero_length();
    int i;
    test_name <= "zero_length";
    push_cmd('0);
    send_event(AcqStart, {TARGET_ADDR, 1'b1});
    end_events();
    wait_error(20);
    // Later events leave the error in place
    send_event(AcqStop, 8'h00);
    end_events();
    for (i = 0; i < 16; i++) begin
      @(negedge clk_i);
      if (!err_o) begin
        flow_errs++;
        $display("%s: err_o fell before reset", test_name);
      end
    end
    apply_reset();
    @(negedge clk_i);
    if (err_o) begin
      flow_errs++;
      $display("%s: err_o still high after reset", test_name);
    end
  endtask

  task automatic check_read_nack();
    int n;
    test_name <= "read_nack";
    ready_en  <= 1'b0;
    push_cmd(LEN_W'(4));
    push_tx($urandom);
    send_event(AcqStart, {TARGET_ADDR, 1'b1});
    end_events();
    n = 0;
    while (!tx_byte_valid_o && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!tx_byte_valid_o) begin
      flow_errs++;
      $display("%s: no byte offered before the nack", test_name);
    end
    send_event(AcqNack, 8'h00);
    end_events();
    wait_error(20);
    ready_en <= 1'b1;
    apply_reset();
  endtask

  task automatic check_rx_overflow();
    int i;
    test_name <= "rx_overflow";
    pop_en    <= 1'b0;
    send_event(AcqStart, {TARGET_ADDR, 1'b0});
    // One byte more than a full RX queue plus a full buffer can take
    for (i = 0; i < 4 * DATA_DEPTH + 5; i++) begin
      send_event(AcqData, BYTE_W'($urandom));
    end
    end_events();
    wait_error(20);
    pop_en <= 1'b1;
    apply_reset();
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni           = 1'b0;
    acq_valid_i      = 1'b0;
    acq_i            = '0;
    cmd_push_valid_i = 1'b0;
    cmd_push_i       = '0;
    tx_push_valid_i  = 1'b0;
    tx_push_i        = '0;
    rx_pop_ready_i   = 1'b0;
    resp_pop_ready_i = 1'b0;
    tx_byte_ready_i  = 1'b0;
    pop_en           = 1'b1;
    stall_en         = 1'b0;
    ready_en         = 1'b1;
    value_errs       = 0;
    flow_errs        = 0;
    bytes_seen       = 0;
    test_name        = "reset";
    apply_reset();
    run_write("write", 9);
    run_read("read", 6, 1'b0);
    run_read("read_stall", 10, 1'b1);
    check_zero_length();
    check_read_nack();
    check_rx_overflow();
    run_write("recovery", 7);
    $display("Errors: %0d value mismatches, %0d flow failures, %0d assertion failures",
             value_errs, flow_errs, UUT.u_fsm.u_props.fail_count);
    if (value_errs == 0 && flow_errs == 0 && UUT.u_fsm.u_props.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the event count of all tests
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run hung", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule : tb_i2c_standby

`default_nettype wire

// ==== xfer_byte_counter.sv ====
// Byte counter of one transfer; clear wins over increment, count wraps at 2**LEN_W
`timescale 1ns/1ns
`default_nettype none

module xfer_byte_counter (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic                             inc_i,
  input  logic [i2c_standby_pkg::LEN_W-1:0] length_i,
  output logic [i2c_standby_pkg::LEN_W-1:0] count_o,
  output logic [1:0]                       lane_o,
  output logic                             last_byte_o
);

  import i2c_standby_pkg::*;

  logic [LEN_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (inc_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  // Low bits select the byte inside the current dword
  assign lane_o = count_q[1:0];

  // High while the byte now in flight is the final one of the read
  assign last_byte_o = ((count_q + 1'b1) == length_i);

endmodule : xfer_byte_counter

`default_nettype wire
